//--- verilog/sched_params.svh
`ifndef SCHED_PARAMS_SVH
`define SCHED_PARAMS_SVH

// scheduler depth
`define SCHED_ENTRY_NUM 4

// entry index width, log2 of the depth
`define SCHED_TAG_W 2

// architectural registers
`define ARCH_REG_NUM 8
`define REG_IDX_W 3

// operand and result width
`define DATA_W 16

`endif

//--- verilog/exec_pkg.sv
`include "sched_params.svh"

package exec_pkg;

  // alu operation codes
  typedef enum logic [1:0] {
    ADD = 2'd0,
    SUB = 2'd1,
    AND = 2'd2,
    XOR = 2'd3
  } alu_op_t;

  // result wraps at DATA_W bits
  function automatic logic [`DATA_W-1:0] alu_calc(input alu_op_t op,
                                                 input logic [`DATA_W-1:0] a,
                                                 input logic [`DATA_W-1:0] b);
    logic [`DATA_W-1:0] res;
    case (op)
      ADD:     res = a + b;
      SUB:     res = a - b;
      AND:     res = a & b;
      default: res = a ^ b;
    endcase
    return res;
  endfunction

endpackage

//--- verilog/sched_pkg.sv
`include "sched_params.svh"

package sched_pkg;

  // scalar types shared by the datapath
  typedef logic [`SCHED_TAG_W-1:0] tag_t;
  typedef logic [`REG_IDX_W-1:0]   reg_idx_t;
  typedef logic [`DATA_W-1:0]      data_t;

  // scheduler slot lifecycle
  typedef enum logic [2:0] {
    INIT          = 3'd0,
    WAIT          = 3'd1,
    ISSUED        = 3'd2,
    DONE          = 3'd3,
    WAIT_COMPLETE = 3'd4
  } sched_state_t;

  // payload handed from dispatch to a scheduler slot
  typedef struct packed {
    exec_pkg::alu_op_t op;
    reg_idx_t          rd;
    reg_idx_t          rs1;
    data_t             rs1_val;
    logic              rs1_ready;
    reg_idx_t          rs2;
    data_t             rs2_val;
    logic              rs2_ready;
  } disp_t;

endpackage

//--- verilog/sched_entry.sv
`timescale 1ns/1ps
`include "sched_params.svh"

module sched_entry (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_put,
  input  sched_pkg::disp_t      i_put_data,
  input  logic                  i_picked,
  input  logic                  i_wb_valid,
  input  logic [`REG_IDX_W-1:0] i_wb_rd,
  input  logic [`DATA_W-1:0]    i_wb_data,
  input  logic                  i_done,
  input  logic                  i_retire,
  output logic                  o_valid,
  output logic                  o_request,
  output sched_pkg::disp_t      o_entry,
  output logic                  o_wait_complete
);
  import sched_pkg::*;

  sched_state_t r_state;
  sched_state_t w_state_next;
  disp_t        r_entry;
  disp_t        w_entry_next;
  logic         w_capture;
  logic         w_rs1_hit;
  logic         w_rs2_hit;

  // operands can still arrive while waiting or already issued
  assign w_capture = i_wb_valid & ((r_state == WAIT) | (r_state == ISSUED));
  assign w_rs1_hit = w_capture & !r_entry.rs1_ready & (r_entry.rs1 == i_wb_rd);
  assign w_rs2_hit = w_capture & !r_entry.rs2_ready & (r_entry.rs2 == i_wb_rd);

  always_comb begin
    w_state_next = r_state;
    w_entry_next = r_entry;

    // wakeup from the writeback bus
    if (w_rs1_hit) begin
      w_entry_next.rs1_val   = i_wb_data;
      w_entry_next.rs1_ready = 1'b1;
    end
    if (w_rs2_hit) begin
      w_entry_next.rs2_val   = i_wb_data;
      w_entry_next.rs2_ready = 1'b1;
    end

    case (r_state)
      INIT: begin
        if (i_put) begin
          w_state_next = WAIT;
          w_entry_next = i_put_data;
        end
      end
      WAIT: begin
        if (i_picked) begin
          w_state_next = ISSUED;
        end
      end
      ISSUED: begin
        // result came back for this tag
        if (i_done) begin
          w_state_next = DONE;
        end
      end
      DONE: begin
        w_state_next = WAIT_COMPLETE;
      end
      WAIT_COMPLETE: begin
        // head pointer reached us, slot is free again
        if (i_retire) begin
          w_state_next = INIT;
        end
      end
      default: begin
        w_state_next = INIT;
      end
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= INIT;
    end else begin
      r_state <= w_state_next;
    end
  end

  always_ff @(posedge i_clk) begin
    r_entry <= w_entry_next;
  end

  assign o_valid         = (r_state != INIT);
  assign o_request       = (r_state == WAIT) & r_entry.rs1_ready & r_entry.rs2_ready;
  assign o_entry         = r_entry;
  assign o_wait_complete = (r_state == WAIT_COMPLETE);

endmodule

//--- verilog/sched_array.sv
`timescale 1ns/1ps
`include "sched_params.svh"

module sched_array (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_disp_valid,
  input  sched_pkg::disp_t        i_disp_data,
  input  logic                    i_wb_valid,
  input  logic [`SCHED_TAG_W-1:0] i_wb_tag,
  input  logic [`REG_IDX_W-1:0]   i_wb_rd,
  input  logic [`DATA_W-1:0]      i_wb_data,
  output logic                    o_full,
  output logic                    o_issue_valid,
  output exec_pkg::alu_op_t       o_issue_op,
  output logic [`DATA_W-1:0]      o_issue_a,
  output logic [`DATA_W-1:0]      o_issue_b,
  output logic [`SCHED_TAG_W-1:0] o_issue_tag,
  output logic [`REG_IDX_W-1:0]   o_issue_rd,
  output logic                    o_retire_valid,
  output logic [`REG_IDX_W-1:0]   o_retire_rd,
  output logic [`DATA_W-1:0]      o_retire_data
);
  import sched_pkg::*;

  localparam logic [`SCHED_TAG_W:0] ENTRY_CNT = `SCHED_ENTRY_NUM;

  tag_t                        r_head;
  tag_t                        r_tail;
  logic [`SCHED_TAG_W:0]       r_count;
  logic [`SCHED_TAG_W:0]       w_occupied;
  logic [`SCHED_ENTRY_NUM-1:0] w_valid;
  logic [`SCHED_ENTRY_NUM-1:0] w_request;
  logic [`SCHED_ENTRY_NUM-1:0] w_wait_complete;
  logic [`SCHED_ENTRY_NUM-1:0] w_put;
  logic [`SCHED_ENTRY_NUM-1:0] w_picked;
  logic [`SCHED_ENTRY_NUM-1:0] w_done;
  logic [`SCHED_ENTRY_NUM-1:0] w_retire_vec;
  disp_t                       w_entry [`SCHED_ENTRY_NUM];
  data_t                       r_result [`SCHED_ENTRY_NUM];
  logic                        w_pick_valid;
  tag_t                        w_pick_idx;
  logic                        w_retire;

  for (genvar i = 0; i < `SCHED_ENTRY_NUM; i++) begin : g_entry
    assign w_put[i]        = i_disp_valid & (r_tail == tag_t'(i));
    assign w_picked[i]     = w_pick_valid & (w_pick_idx == tag_t'(i));
    assign w_done[i]       = i_wb_valid & (i_wb_tag == tag_t'(i));
    assign w_retire_vec[i] = w_retire & (r_head == tag_t'(i));

    sched_entry u_entry (
      .i_clk           (i_clk),
      .i_reset_n       (i_reset_n),
      .i_put           (w_put[i]),
      .i_put_data      (i_disp_data),
      .i_picked        (w_picked[i]),
      .i_wb_valid      (i_wb_valid),
      .i_wb_rd         (i_wb_rd),
      .i_wb_data       (i_wb_data),
      .i_done          (w_done[i]),
      .i_retire        (w_retire_vec[i]),
      .o_valid         (w_valid[i]),
      .o_request       (w_request[i]),
      .o_entry         (w_entry[i]),
      .o_wait_complete (w_wait_complete[i])
    );
  end

  // oldest ready pick, scanning from the head
  always_comb begin
    tag_t idx;
    w_pick_valid = 1'b0;
    w_pick_idx   = r_head;
    for (int k = 0; k < `SCHED_ENTRY_NUM; k++) begin
      idx = r_head + tag_t'(k);
      if (!w_pick_valid && w_request[idx]) begin
        w_pick_valid = 1'b1;
        w_pick_idx   = idx;
      end
    end
  end

  // count the dispatch already on its way in
  assign w_occupied = r_count + {{`SCHED_TAG_W{1'b0}}, i_disp_valid};
  assign o_full     = (w_occupied >= ENTRY_CNT);

  assign w_retire = w_valid[r_head] & w_wait_complete[r_head];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head        <= '0;
      r_tail        <= '0;
      r_count       <= '0;
      o_issue_valid <= 1'b0;
    end else begin
      if (i_disp_valid) begin
        r_tail <= r_tail + 1'b1;
      end
      if (w_retire) begin
        r_head <= r_head + 1'b1;
      end
      case ({i_disp_valid, w_retire})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
      o_issue_valid <= w_pick_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_pick_valid) begin
      o_issue_op  <= w_entry[w_pick_idx].op;
      o_issue_a   <= w_entry[w_pick_idx].rs1_val;
      o_issue_b   <= w_entry[w_pick_idx].rs2_val;
      o_issue_tag <= w_pick_idx;
      o_issue_rd  <= w_entry[w_pick_idx].rd;
    end
    // result parked per slot until retirement
    if (i_wb_valid) begin
      r_result[i_wb_tag] <= i_wb_data;
    end
  end

  assign o_retire_valid = w_retire;
  assign o_retire_rd    = w_entry[r_head].rd;
  assign o_retire_data  = r_result[r_head];

endmodule

//--- verilog/dispatch_ctrl.sv
`timescale 1ns/1ps
`include "sched_params.svh"

module dispatch_ctrl (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_inst_valid,
  input  exec_pkg::alu_op_t     i_inst_op,
  input  logic [`REG_IDX_W-1:0] i_inst_rd,
  input  logic [`REG_IDX_W-1:0] i_inst_rs1,
  input  logic [`REG_IDX_W-1:0] i_inst_rs2,
  input  logic                  i_sched_full,
  input  logic                  i_wb_valid,
  input  logic [`REG_IDX_W-1:0] i_wb_rd,
  input  logic [`DATA_W-1:0]    i_wb_data,
  output logic                  o_inst_ready,
  output logic                  o_disp_valid,
  output sched_pkg::disp_t      o_disp_data
);
  import sched_pkg::*;

  data_t                    r_regs [`ARCH_REG_NUM];
  logic [`ARCH_REG_NUM-1:0] r_pending;
  logic [`ARCH_REG_NUM-1:0] w_wb_clear;
  logic [`ARCH_REG_NUM-1:0] w_disp_set;
  logic [`ARCH_REG_NUM-1:0] w_pend_eff;
  logic                     w_accept;
  disp_t                    w_payload;

  always_comb begin
    for (int r = 0; r < `ARCH_REG_NUM; r++) begin
      w_wb_clear[r] = i_wb_valid & (i_wb_rd == reg_idx_t'(r));
      w_disp_set[r] = w_accept & (i_inst_rd == reg_idx_t'(r));
    end
  end

  // a register written back this cycle no longer counts as pending
  assign w_pend_eff   = r_pending & ~w_wb_clear;
  assign o_inst_ready = !i_sched_full & !w_pend_eff[i_inst_rd] &
                        !w_pend_eff[i_inst_rs1] & !w_pend_eff[i_inst_rs2];
  assign w_accept     = i_inst_valid & o_inst_ready;

  // operand read with writeback bypass
  always_comb begin
    w_payload.op        = i_inst_op;
    w_payload.rd        = i_inst_rd;
    w_payload.rs1       = i_inst_rs1;
    w_payload.rs1_val   = w_wb_clear[i_inst_rs1] ? i_wb_data : r_regs[i_inst_rs1];
    w_payload.rs1_ready = !w_pend_eff[i_inst_rs1];
    w_payload.rs2       = i_inst_rs2;
    w_payload.rs2_val   = w_wb_clear[i_inst_rs2] ? i_wb_data : r_regs[i_inst_rs2];
    w_payload.rs2_ready = !w_pend_eff[i_inst_rs2];
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      // register k starts out holding k
      for (int k = 0; k < `ARCH_REG_NUM; k++) begin
        r_regs[k] <= data_t'(k);
      end
      r_pending    <= '0;
      o_disp_valid <= 1'b0;
    end else begin
      if (i_wb_valid) begin
        r_regs[i_wb_rd] <= i_wb_data;
      end
      // new writer wins over a clear of the same register
      r_pending    <= w_pend_eff | w_disp_set;
      o_disp_valid <= w_accept;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      o_disp_data <= w_payload;
    end
  end

endmodule

//--- verilog/alu_pipe.sv
`timescale 1ns/1ps
`include "sched_params.svh"

module alu_pipe (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_issue_valid,
  input  exec_pkg::alu_op_t       i_issue_op,
  input  logic [`DATA_W-1:0]      i_issue_a,
  input  logic [`DATA_W-1:0]      i_issue_b,
  input  logic [`SCHED_TAG_W-1:0] i_issue_tag,
  input  logic [`REG_IDX_W-1:0]   i_issue_rd,
  output logic                    o_wb_valid,
  output logic [`SCHED_TAG_W-1:0] o_wb_tag,
  output logic [`REG_IDX_W-1:0]   o_wb_rd,
  output logic [`DATA_W-1:0]      o_wb_data
);
  import sched_pkg::*;
  import exec_pkg::*;

  logic     r_s1_valid;
  tag_t     r_s1_tag;
  reg_idx_t r_s1_rd;
  data_t    r_s1_data;

  // valid bits of both stages
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      o_wb_valid <= 1'b0;
    end else begin
      r_s1_valid <= i_issue_valid;
      o_wb_valid <= r_s1_valid;
    end
  end

  // stage one computes, stage two drives the writeback bus
  always_ff @(posedge i_clk) begin
    r_s1_tag  <= i_issue_tag;
    r_s1_rd   <= i_issue_rd;
    r_s1_data <= alu_calc(i_issue_op, i_issue_a, i_issue_b);

    o_wb_tag  <= r_s1_tag;
    o_wb_rd   <= r_s1_rd;
    o_wb_data <= r_s1_data;
  end

endmodule

//--- verilog/sched_top.sv
`timescale 1ns/1ps
`include "sched_params.svh"

module sched_top (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_inst_valid,
  input  exec_pkg::alu_op_t     i_inst_op,
  input  logic [`REG_IDX_W-1:0] i_inst_rd,
  input  logic [`REG_IDX_W-1:0] i_inst_rs1,
  input  logic [`REG_IDX_W-1:0] i_inst_rs2,
  output logic                  o_inst_ready,
  output logic                  o_retire_valid,
  output logic [`REG_IDX_W-1:0] o_retire_rd,
  output logic [`DATA_W-1:0]    o_retire_data,
  output logic                  o_wb_valid,
  output logic [`REG_IDX_W-1:0] o_wb_rd,
  output logic [`DATA_W-1:0]    o_wb_data
);

  logic                    w_sched_full;
  logic                    w_disp_valid;
  sched_pkg::disp_t        w_disp_data;
  logic                    w_issue_valid;
  exec_pkg::alu_op_t       w_issue_op;
  logic [`DATA_W-1:0]      w_issue_a;
  logic [`DATA_W-1:0]      w_issue_b;
  logic [`SCHED_TAG_W-1:0] w_issue_tag;
  logic [`REG_IDX_W-1:0]   w_issue_rd;
  logic [`SCHED_TAG_W-1:0] w_wb_tag;

  dispatch_ctrl u_dispatch (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_inst_valid (i_inst_valid),
    .i_inst_op    (i_inst_op),
    .i_inst_rd    (i_inst_rd),
    .i_inst_rs1   (i_inst_rs1),
    .i_inst_rs2   (i_inst_rs2),
    .i_sched_full (w_sched_full),
    .i_wb_valid   (o_wb_valid),
    .i_wb_rd      (o_wb_rd),
    .i_wb_data    (o_wb_data),
    .o_inst_ready (o_inst_ready),
    .o_disp_valid (w_disp_valid),
    .o_disp_data  (w_disp_data)
  );

  sched_array u_sched (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_disp_valid   (w_disp_valid),
    .i_disp_data    (w_disp_data),
    .i_wb_valid     (o_wb_valid),
    .i_wb_tag       (w_wb_tag),
    .i_wb_rd        (o_wb_rd),
    .i_wb_data      (o_wb_data),
    .o_full         (w_sched_full),
    .o_issue_valid  (w_issue_valid),
    .o_issue_op     (w_issue_op),
    .o_issue_a      (w_issue_a),
    .o_issue_b      (w_issue_b),
    .o_issue_tag    (w_issue_tag),
    .o_issue_rd     (w_issue_rd),
    .o_retire_valid (o_retire_valid),
    .o_retire_rd    (o_retire_rd),
    .o_retire_data  (o_retire_data)
  );

  // writeback feeds both the scheduler wakeup and the register file
  alu_pipe u_alu (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_issue_valid (w_issue_valid),
    .i_issue_op    (w_issue_op),
    .i_issue_a     (w_issue_a),
    .i_issue_b     (w_issue_b),
    .i_issue_tag   (w_issue_tag),
    .i_issue_rd    (w_issue_rd),
    .o_wb_valid    (o_wb_valid),
    .o_wb_tag      (w_wb_tag),
    .o_wb_rd       (o_wb_rd),
    .o_wb_data     (o_wb_data)
  );

endmodule

//--- verification/sched_checker.sv
`timescale 1ns/1ps
`include "sched_params.svh"

module sched_checker (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_inst_valid,
  input  exec_pkg::alu_op_t     i_inst_op,
  input  logic [`REG_IDX_W-1:0] i_inst_rd,
  input  logic [`REG_IDX_W-1:0] i_inst_rs1,
  input  logic [`REG_IDX_W-1:0] i_inst_rs2,
  input  logic                  i_inst_ready,
  input  logic                  i_row_active,
  input  logic                  i_expect_stall,
  input  logic                  i_wb_valid,
  input  logic [`REG_IDX_W-1:0] i_wb_rd,
  input  logic [`DATA_W-1:0]    i_wb_data,
  input  logic                  i_retire_valid,
  input  logic [`REG_IDX_W-1:0] i_retire_rd,
  input  logic [`DATA_W-1:0]    i_retire_data,
  input  logic [95:0]           i_test_name,
  output int                    o_pending,
  output int                    o_errors,
  output int                    o_checks
);
  import exec_pkg::*;

  logic [`DATA_W-1:0]    model_regs [`ARCH_REG_NUM];
  logic                  wb_open [`ARCH_REG_NUM];
  logic [`DATA_W-1:0]    wb_exp [`ARCH_REG_NUM];
  logic [95:0]           wb_name [`ARCH_REG_NUM];
  logic                  saw_stall;
  logic [`REG_IDX_W-1:0] exp_rd [$];
  logic [`DATA_W-1:0]    exp_data [$];
  logic [95:0]           exp_name [$];

  // two operands combined by the op, wrapped to DATA_W bits
  function automatic logic [`DATA_W-1:0] expected_result(input alu_op_t op,
                                                         input logic [`DATA_W-1:0] a,
                                                         input logic [`DATA_W-1:0] b);
    logic [`DATA_W:0] wide;
    case (op)
      ADD:     wide = {1'b0, a} + {1'b0, b};
      SUB:     wide = {1'b1, a} - {1'b0, b};
      AND:     wide = {1'b0, a & b};
      default: wide = {1'b0, a ^ b};
    endcase
    return wide[`DATA_W-1:0];
  endfunction

  always @(posedge i_clk) begin
    logic [`DATA_W-1:0] res;
    if (!i_reset_n) begin
      // register k starts out holding k
      for (int k = 0; k < `ARCH_REG_NUM; k++) begin
        model_regs[k] = `DATA_W'(k);
        wb_open[k]    = 1'b0;
      end
      exp_rd.delete();
      exp_data.delete();
      exp_name.delete();
      saw_stall = 1'b0;
      o_errors  = 0;
      o_checks  = 0;
    end else begin
      // retirements must come back in dispatch order
      if (i_retire_valid) begin
        if (exp_rd.size() == 0) begin
          $display("retirement of r%0d arrived with no instruction outstanding", i_retire_rd);
          o_errors++;
        end else begin
          o_checks++;
          if (i_retire_rd !== exp_rd[0]) begin
            $display("[FAIL] %0s: retire rd expected r%0d actual r%0d",
                     exp_name[0], exp_rd[0], i_retire_rd);
            o_errors++;
          end
          if (i_retire_data !== exp_data[0]) begin
            $display("[FAIL] %0s: retire data of r%0d expected 0x%h actual 0x%h",
                     exp_name[0], exp_rd[0], exp_data[0], i_retire_data);
            o_errors++;
          end
          void'(exp_rd.pop_front());
          void'(exp_data.pop_front());
          void'(exp_name.pop_front());
        end
      end
      // writebacks come in any order, one writer per register at a time
      if (i_wb_valid) begin
        if (!wb_open[i_wb_rd]) begin
          $display("writeback to r%0d arrived with no writer in flight", i_wb_rd);
          o_errors++;
        end else begin
          if (i_wb_data !== wb_exp[i_wb_rd]) begin
            $display("[FAIL] %0s: writeback data of r%0d expected 0x%h actual 0x%h",
                     wb_name[i_wb_rd], i_wb_rd, wb_exp[i_wb_rd], i_wb_data);
            o_errors++;
          end
          wb_open[i_wb_rd] = 1'b0;
        end
      end
      // a row that must wait sees o_inst_ready low first
      if (i_row_active && !i_inst_ready) begin
        saw_stall = 1'b1;
      end
      // model register file advances in program order
      if (i_inst_valid && i_inst_ready) begin
        if (i_expect_stall && !saw_stall) begin
          $display("[FAIL] %0s: o_inst_ready stall for r%0d expected 1 actual 0",
                   i_test_name, i_inst_rd);
          o_errors++;
        end
        saw_stall = 1'b0;
        res = expected_result(i_inst_op, model_regs[i_inst_rs1], model_regs[i_inst_rs2]);
        model_regs[i_inst_rd] = res;
        wb_open[i_inst_rd]    = 1'b1;
        wb_exp[i_inst_rd]     = res;
        wb_name[i_inst_rd]    = i_test_name;
        exp_rd.push_back(i_inst_rd);
        exp_data.push_back(res);
        exp_name.push_back(i_test_name);
      end
    end
    o_pending = exp_rd.size();
  end

endmodule

//--- verification/tb_sched_top.sv
`timescale 1ns/1ps
`include "sched_params.svh"

module tb_sched_top;
  import exec_pkg::*;

  localparam int TEST_NUM       = 6;
  localparam int TIMEOUT_CYCLES = 300;

  // one instruction of the stimulus table
  typedef struct packed {
    logic [2:0]            test;
    alu_op_t               op;
    logic [`REG_IDX_W-1:0] rd;
    logic [`REG_IDX_W-1:0] rs1;
    logic [`REG_IDX_W-1:0] rs2;
    logic                  must_stall;
  } row_t;

  logic                  clk;
  logic                  reset_n;
  logic                  inst_valid;
  alu_op_t               inst_op;
  logic [`REG_IDX_W-1:0] inst_rd;
  logic [`REG_IDX_W-1:0] inst_rs1;
  logic [`REG_IDX_W-1:0] inst_rs2;
  logic                  inst_ready;
  logic                  retire_valid;
  logic [`REG_IDX_W-1:0] retire_rd;
  logic [`DATA_W-1:0]    retire_data;
  logic                  wb_valid;
  logic [`REG_IDX_W-1:0] wb_rd;
  logic [`DATA_W-1:0]    wb_data;
  logic                  row_active;
  logic                  expect_stall;
  logic                  timed_out;
  logic [95:0]           cur_name;
  logic [95:0]           test_names [TEST_NUM];
  row_t                  rows [$];
  int                    seed;
  int                    chk_pending;
  int                    chk_errors;
  int                    chk_checks;

  always #50 clk = ~clk;

  sched_top dut_i (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_inst_valid   (inst_valid),
    .i_inst_op      (inst_op),
    .i_inst_rd      (inst_rd),
    .i_inst_rs1     (inst_rs1),
    .i_inst_rs2     (inst_rs2),
    .o_inst_ready   (inst_ready),
    .o_retire_valid (retire_valid),
    .o_retire_rd    (retire_rd),
    .o_retire_data  (retire_data),
    .o_wb_valid     (wb_valid),
    .o_wb_rd        (wb_rd),
    .o_wb_data      (wb_data)
  );

  sched_checker chk_i (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_inst_valid   (inst_valid),
    .i_inst_op      (inst_op),
    .i_inst_rd      (inst_rd),
    .i_inst_rs1     (inst_rs1),
    .i_inst_rs2     (inst_rs2),
    .i_inst_ready   (inst_ready),
    .i_row_active   (row_active),
    .i_expect_stall (expect_stall),
    .i_wb_valid     (wb_valid),
    .i_wb_rd        (wb_rd),
    .i_wb_data      (wb_data),
    .i_retire_valid (retire_valid),
    .i_retire_rd    (retire_rd),
    .i_retire_data  (retire_data),
    .i_test_name    (cur_name),
    .o_pending      (chk_pending),
    .o_errors       (chk_errors),
    .o_checks       (chk_checks)
  );

  task automatic add_row(input int test, input alu_op_t op, input int rd, input int rs1,
                         input int rs2, input logic must_stall);
    row_t row;
    row.test       = test[2:0];
    row.op         = op;
    row.rd         = rd[`REG_IDX_W-1:0];
    row.rs1        = rs1[`REG_IDX_W-1:0];
    row.rs2        = rs2[`REG_IDX_W-1:0];
    row.must_stall = must_stall;
    rows.push_back(row);
  endtask

  task automatic build_table();
    int r;
    // independent ops on reset values
    add_row(0, ADD, 1, 2, 3, 1'b0);
    add_row(0, SUB, 4, 5, 6, 1'b0);
    add_row(0, AND, 7, 6, 5, 1'b0);
    add_row(0, XOR, 0, 3, 2, 1'b0);
    // read-after-write chain, each link waits for its source
    add_row(1, ADD, 1, 1, 2, 1'b0);
    add_row(1, ADD, 2, 1, 1, 1'b1);
    add_row(1, SUB, 3, 2, 1, 1'b1);
    add_row(1, XOR, 1, 3, 2, 1'b1);
    // slow chain then younger independent ops
    add_row(2, ADD, 4, 4, 4, 1'b0);
    add_row(2, ADD, 4, 4, 1, 1'b1);
    add_row(2, SUB, 5, 6, 7, 1'b0);
    add_row(2, AND, 6, 7, 0, 1'b0);
    add_row(2, XOR, 7, 0, 2, 1'b0);
    // same destination twice
    add_row(3, ADD, 3, 1, 2, 1'b0);
    add_row(3, XOR, 3, 4, 5, 1'b1);
    add_row(3, SUB, 6, 3, 0, 1'b1);
    // fifth one finds the scheduler full
    add_row(4, ADD, 1, 6, 7, 1'b0);
    add_row(4, SUB, 2, 7, 6, 1'b0);
    add_row(4, AND, 3, 6, 7, 1'b0);
    add_row(4, XOR, 4, 7, 6, 1'b0);
    add_row(4, ADD, 5, 6, 6, 1'b1);
    for (int i = 0; i < 20; i++) begin
      r = $random(seed);
      add_row(5, alu_op_t'(r[1:0]), r[4:2], r[7:5], r[10:8], 1'b0);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %0s after %0d cycles", what, TIMEOUT_CYCLES);
    timed_out = 1'b1;
  endtask

  // presents a row at a falling edge and strobes it once o_inst_ready is high
  task automatic apply_row(input row_t row);
    int waited;
    waited       = 0;
    inst_op      = row.op;
    inst_rd      = row.rd;
    inst_rs1     = row.rs1;
    inst_rs2     = row.rs2;
    expect_stall = row.must_stall;
    row_active   = 1'b1;
    while (!inst_ready && !timed_out) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        report_timeout("o_inst_ready never rose");
      end else begin
        @(negedge clk);
      end
    end
    if (!timed_out) begin
      inst_valid = 1'b1;
      @(negedge clk);
    end
    inst_valid = 1'b0;
    row_active = 1'b0;
  endtask

  task automatic wait_for_retirements();
    int waited;
    waited = 0;
    while (chk_pending != 0 && !timed_out) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        report_timeout("instructions never retired");
      end else begin
        @(negedge clk);
      end
    end
  endtask

  initial begin
    int failed_tests;
    int errs_before;
    int errs_now;
    clk           = 1'b0;
    reset_n       = 1'b0;
    inst_valid    = 1'b0;
    inst_op       = ADD;
    inst_rd       = '0;
    inst_rs1      = '0;
    inst_rs2      = '0;
    row_active    = 1'b0;
    expect_stall  = 1'b0;
    timed_out     = 1'b0;
    seed          = 32'hb37d;
    failed_tests  = 0;
    cur_name      = '0;
    test_names[0] = "indep_ops";
    test_names[1] = "raw_chain";
    test_names[2] = "ooo_retire";
    test_names[3] = "waw_stall";
    test_names[4] = "fill_sched";
    test_names[5] = "random_ops";
    build_table();

    repeat (3) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    for (int t = 0; t < TEST_NUM && !timed_out; t++) begin
      cur_name    = test_names[t];
      errs_before = chk_errors;
      foreach (rows[i]) begin
        if (rows[i].test == t[2:0] && !timed_out) begin
          apply_row(rows[i]);
        end
      end
      wait_for_retirements();
      errs_now = chk_errors - errs_before;
      if (timed_out) begin
        $display("test %0s: timed out", cur_name);
        failed_tests++;
      end else if (errs_now == 0) begin
        $display("test %0s: ok", cur_name);
      end else begin
        $display("test %0s: %0d errors", cur_name, errs_now);
        failed_tests++;
      end
    end

    $display("tests %0d, failed %0d, retirements checked %0d, errors %0d",
             TEST_NUM, failed_tests, chk_checks, chk_errors);
    if (!timed_out && failed_tests == 0 && chk_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+verilog
verilog/exec_pkg.sv
verilog/sched_pkg.sv
verilog/sched_entry.sv
verilog/sched_array.sv
verilog/dispatch_ctrl.sv
verilog/alu_pipe.sv
verilog/sched_top.sv
verification/sched_checker.sv
verification/tb_sched_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_sched_top -o tb_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "sim passed" sim.log && exit 0 || exit 1
